// ==== filelist.f ====
rtl/ocyrus_pkg.sv
rtl/ocyrus_word_buffer.sv
rtl/ocyrus_strobe_gen.sv
rtl/ocyrus_serializer_bank.sv
rtl/ocyrus_output_stage.sv
rtl/ocyrus_tx.sv
verification/ocyrus_tx_assert.sv
verification/ocyrus_tx_tb.sv

// ==== rtl/ocyrus_output_stage.sv ====
module ocyrus_output_stage #(
	parameter int                   NUM_LANES   = 4,
	parameter logic [NUM_LANES-1:0] LANE_INVERT = 4'b0101 // lanes with swapped p/n
) (
	input  logic                 bit_clock,
	input  logic                 reset,
	input  logic [NUM_LANES-1:0] lane_bits,
	input  logic                 word_start,
	output logic [NUM_LANES-1:0] data_out,
	output logic                 word_frame // high with the msb of each word
);

	logic active; // a word has gone out since reset

	// hold the pins low until the first word, so inverted lanes
	// do not show the empty shift registers as ones
	always_ff @(posedge bit_clock) begin
		if (reset) begin
			active     <= 1'b0;
			word_frame <= 1'b0;
			data_out   <= '0;
		end else begin
			active     <= active | word_start;
			word_frame <= word_start; // lines up with the msb below
			if (active | word_start) begin
				data_out <= lane_bits ^ LANE_INVERT;
			end else begin
				data_out <= '0;
			end
		end
	end

endmodule

// ==== rtl/ocyrus_pkg.sv ====
package ocyrus_pkg;

	// bit_clock cycles per word, also the lane word width
	localparam int BIT_DEPTH = 8;

	// word strobes counted after reset before locked rises
	localparam int LOCK_STROBES = 4;

	typedef logic [BIT_DEPTH-1:0] word_t; // one lane word, sent msb first
	typedef logic [2:0] bit_index_t; // bit position within a word period
	typedef logic [2:0] lock_count_t; // strobes seen while settling

	// lock sequence, stands in for pll lock plus strobe alignment
	typedef enum logic [1:0] {
		LOCK_RESET  = 2'd0, // waiting for first strobe
		LOCK_SETTLE = 2'd1, // counting strobes
		LOCK_DONE   = 2'd2  // locked until next reset
	} lock_state_t;

	// sent on every lane when no group is waiting (k28.5 style comma byte)
	localparam word_t IDLE_WORD = 8'hBC;

endpackage

// ==== rtl/ocyrus_serializer_bank.sv ====
module ocyrus_serializer_bank #(
	parameter int NUM_LANES = 4
) (
	input  logic                              bit_clock,
	input  logic                              reset,
	input  logic                              bit_strobe,
	input  logic                              locked,
	input  logic                              held_valid,
	input  ocyrus_pkg::word_t [NUM_LANES-1:0] held_words,
	output logic                              take, // pops the buffer, loads the lanes
	output logic [NUM_LANES-1:0]              lane_bits, // msb of each shift register
	output logic                              word_start // first bit cycle after a load
);

	// locked is registered, so the strobe that raises it is not a take
	assign take = bit_strobe & locked;

	always_ff @(posedge bit_clock) begin
		if (reset) begin
			word_start <= 1'b0;
		end else begin
			word_start <= take;
		end
	end

	for (genvar lane = 0; lane < NUM_LANES; lane++) begin : g_lane
		ocyrus_pkg::word_t shift_reg;
		ocyrus_pkg::word_t next_word; // what this lane loads on a take

		assign next_word = held_valid ? held_words[lane] : ocyrus_pkg::IDLE_WORD;

		always_ff @(posedge bit_clock) begin
			if (reset) begin
				shift_reg <= '0; // quiet line until the first take
			end else if (take) begin
				shift_reg <= next_word;
			end else begin
				shift_reg <= {shift_reg[ocyrus_pkg::BIT_DEPTH-2:0], 1'b0}; // msb first
			end
		end

		assign lane_bits[lane] = shift_reg[ocyrus_pkg::BIT_DEPTH-1];
	end

endmodule

// ==== rtl/ocyrus_strobe_gen.sv ====
module ocyrus_strobe_gen (
	input  logic bit_clock,
	input  logic reset,
	output logic bit_strobe, // last bit cycle of each word period
	output logic locked
);

	ocyrus_pkg::bit_index_t bit_count; // position within the word period
	ocyrus_pkg::lock_count_t lock_count; // strobes counted so far
	ocyrus_pkg::lock_state_t lock_state;

	assign bit_strobe = (bit_count == ocyrus_pkg::bit_index_t'(ocyrus_pkg::BIT_DEPTH - 1));
	assign locked = (lock_state == ocyrus_pkg::LOCK_DONE);

	// divide bit_clock by BIT_DEPTH, zero in the first cycle out of reset
	always_ff @(posedge bit_clock) begin
		if (reset) begin
			bit_count <= '0;
		end else if (bit_strobe) begin
			bit_count <= '0; // wrap
		end else begin
			bit_count <= bit_count + 1'b1;
		end
	end

	// lock rises on the edge of the LOCK_STROBES-th strobe
	always_ff @(posedge bit_clock) begin
		if (reset) begin
			lock_state <= ocyrus_pkg::LOCK_RESET;
			lock_count <= '0;
		end else begin
			case (lock_state)
				ocyrus_pkg::LOCK_RESET: begin
					if (bit_strobe) begin
						lock_state <= ocyrus_pkg::LOCK_SETTLE;
						lock_count <= ocyrus_pkg::lock_count_t'(1); // first strobe counts
					end
				end
				ocyrus_pkg::LOCK_SETTLE: begin
					if (bit_strobe) begin
						if (lock_count == ocyrus_pkg::lock_count_t'(ocyrus_pkg::LOCK_STROBES - 1)) begin
							lock_state <= ocyrus_pkg::LOCK_DONE;
						end else begin
							lock_count <= lock_count + 1'b1;
						end
					end
				end
				ocyrus_pkg::LOCK_DONE: begin
					lock_state <= ocyrus_pkg::LOCK_DONE; // sticky until reset
				end
				default: begin
					lock_state <= ocyrus_pkg::LOCK_RESET;
				end
			endcase
		end
	end

endmodule

// ==== rtl/ocyrus_tx.sv ====
module ocyrus_tx #(
	parameter int                   NUM_LANES   = 4,
	parameter logic [NUM_LANES-1:0] LANE_INVERT = 4'b0101
) (
	input  logic                              bit_clock,
	input  logic                              reset,
	input  logic                              in_valid,
	input  ocyrus_pkg::word_t [NUM_LANES-1:0] in_words, // lane 0 lowest
	output logic                              in_ready,
	output logic [NUM_LANES-1:0]              data_out,
	output logic                              word_frame,
	output logic                              locked
);

	logic                              take; // bank pops the buffer
	logic                              held_valid;
	ocyrus_pkg::word_t [NUM_LANES-1:0] held_words;
	logic                              bit_strobe;
	logic [NUM_LANES-1:0]              lane_bits;
	logic                              word_start;

	ocyrus_word_buffer #(
		.NUM_LANES(NUM_LANES)
	) i_word_buffer (
		.bit_clock  (bit_clock),
		.reset      (reset),
		.in_valid   (in_valid),
		.take       (take),
		.in_words   (in_words),
		.in_ready   (in_ready),
		.held_valid (held_valid),
		.held_words (held_words)
	);

	ocyrus_strobe_gen i_strobe_gen (
		.bit_clock  (bit_clock),
		.reset      (reset),
		.bit_strobe (bit_strobe),
		.locked     (locked)
	);

	ocyrus_serializer_bank #(
		.NUM_LANES(NUM_LANES)
	) i_serializer_bank (
		.bit_clock  (bit_clock),
		.reset      (reset),
		.bit_strobe (bit_strobe),
		.locked     (locked),
		.held_valid (held_valid),
		.held_words (held_words),
		.take       (take),
		.lane_bits  (lane_bits),
		.word_start (word_start)
	);

	ocyrus_output_stage #(
		.NUM_LANES   (NUM_LANES),
		.LANE_INVERT (LANE_INVERT)
	) i_output_stage (
		.bit_clock  (bit_clock),
		.reset      (reset),
		.lane_bits  (lane_bits),
		.word_start (word_start),
		.data_out   (data_out),
		.word_frame (word_frame)
	);

endmodule

// ==== rtl/ocyrus_word_buffer.sv ====
module ocyrus_word_buffer #(
	parameter int NUM_LANES = 4
) (
	input  logic                                   bit_clock,
	input  logic                                   reset,
	input  logic                                   in_valid,
	input  logic                                   take, // pop pulse from the bank
	input  ocyrus_pkg::word_t [NUM_LANES-1:0]      in_words, // lane 0 lowest
	output logic                                   in_ready,
	output logic                                   held_valid,
	output ocyrus_pkg::word_t [NUM_LANES-1:0]      held_words
);

	logic full; // a group is waiting for the next take
	logic accept; // transfer on this edge

	// free slot, or the slot empties on this same edge
	assign in_ready = ~full | take;
	assign accept = in_valid & in_ready;
	assign held_valid = full;

	always_ff @(posedge bit_clock) begin
		if (reset) begin
			full <= 1'b0;
		end else if (accept) begin
			full <= 1'b1; // new group replaces the one being popped
		end else if (take) begin
			full <= 1'b0; // popped with nothing behind it
		end
	end

	// payload only moves on accept, so a held group stays put until popped
	always_ff @(posedge bit_clock) begin
		if (accept) begin
			held_words <= in_words;
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ocyrus_tx testbench with verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module ocyrus_tx_tb -f filelist.f \
	&& ./obj_dir/Vocyrus_tx_tb > sim.log 2>&1 \
	|| echo "build or run returned an error"
cat sim.log 2>/dev/null
grep -qx "SIMULATION PASSED" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }

// ==== verification/ocyrus_tx_assert.sv ====
module ocyrus_tx_assert #(
	parameter int NUM_LANES = 4
) (
	input logic                              bit_clock,
	input logic                              reset,
	input logic                              in_valid,
	input ocyrus_pkg::word_t [NUM_LANES-1:0] in_words,
	input logic                              in_ready,
	input logic                              word_frame,
	input logic                              locked
);

	timeunit 1ns;
	timeprecision 1ps;

	int since_frame; // edges since the last word_frame
	logic framed; // a word_frame was seen since reset

	always_ff @(posedge bit_clock) begin
		if (reset) begin
			framed <= 1'b0;
			since_frame <= 0;
		end else if (word_frame) begin
			framed <= 1'b1;
			since_frame <= 1;
		end else begin
			since_frame <= since_frame + 1;
		end
	end

	frame_period: assert property (@(posedge bit_clock) disable iff (reset)
		framed && word_frame |-> since_frame == ocyrus_pkg::BIT_DEPTH)
		else $error("word_frame came early");
	frame_gap: assert property (@(posedge bit_clock) disable iff (reset)
		framed && !word_frame |-> since_frame < ocyrus_pkg::BIT_DEPTH)
		else $error("word_frame missing");
	lock_sticky: assert property (@(posedge bit_clock) disable iff (reset)
		locked |=> locked)
		else $error("locked fell outside reset");
	input_hold: assert property (@(posedge bit_clock) disable iff (reset)
		in_valid && !in_ready |=> in_valid && $stable(in_words))
		else $error("input group changed before transfer");

endmodule

bind ocyrus_tx ocyrus_tx_assert #(
	.NUM_LANES(NUM_LANES)
) i_tx_assert (
	.bit_clock  (bit_clock),
	.reset      (reset),
	.in_valid   (in_valid),
	.in_words   (in_words),
	.in_ready   (in_ready),
	.word_frame (word_frame),
	.locked     (locked)
);

// ==== verification/ocyrus_tx_tb.sv ====
module ocyrus_tx_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_LANES = 4;
	localparam logic [NUM_LANES-1:0] LANE_INVERT = 4'b0101;
	localparam int CLOCK_PERIOD = 40;
	localparam int DRIVE_DELAY = 2; // inputs move this long after the rising edge
	localparam int RESET_CYCLES = 16;
	localparam int SEED = 40;
	localparam int LOCK_TIMEOUT = 100; // cycles
	localparam int XFER_TIMEOUT = 40; // cycles for one group to be taken
	localparam int FRAME_TIMEOUT = 40; // cycles between two word_frame pulses
	localparam int STREAM_GROUPS = 20;
	localparam int BURST_GROUPS = 12;

	typedef ocyrus_pkg::word_t [NUM_LANES-1:0] group_t; // lane 0 lowest

	logic bit_clock;
	logic reset;
	logic in_valid;
	group_t in_words;
	logic in_ready;
	logic [NUM_LANES-1:0] data_out;
	logic word_frame;
	logic locked;

	int errors = 0;
	int checks = 0;
	int tests = 0;
	int errors_at_start = 0; // errors before the running test
	int acc_count = 0; // groups the DUT took, seen from the driver

	// reference model, advanced on every rising edge
	logic m_known = 1'b0; // set once the model has seen a reset edge
	int m_count; // bit position in the word period
	int m_strobes; // strobes since reset
	logic m_locked;
	logic m_full;
	group_t m_held; // group waiting in the buffer
	group_t m_load; // group loaded on the last take
	group_t m_out; // group now on the pins
	logic m_take_d; // take on the previous edge
	logic m_active; // pins carry words
	int m_bit; // bits of m_out already sent
	int sent_count = 0; // groups popped from the buffer
	logic exp_ready;
	logic exp_frame;
	logic [NUM_LANES-1:0] exp_data;

	ocyrus_tx #(
		.NUM_LANES   (NUM_LANES),
		.LANE_INVERT (LANE_INVERT)
	) i_dut (
		.bit_clock  (bit_clock),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_words   (in_words),
		.in_ready   (in_ready),
		.data_out   (data_out),
		.word_frame (word_frame),
		.locked     (locked)
	);

	initial begin
		bit_clock = 1'b0;
		forever begin
			#(CLOCK_PERIOD / 2);
			bit_clock = ~bit_clock;
		end
	end

	always @(posedge bit_clock) begin
		logic take_edge;
		logic accept;
		logic [NUM_LANES-1:0] msbs;
		ocyrus_pkg::word_t shifted;
		take_edge = (m_count == ocyrus_pkg::BIT_DEPTH - 1) && m_locked; // lock edge itself excluded
		accept = in_valid && (!m_full || take_edge);
		if (reset) begin
			m_known = 1'b1;
			m_count = 0;
			m_strobes = 0;
			m_locked = 1'b0;
			m_full = 1'b0;
			m_take_d = 1'b0;
			m_active = 1'b0;
			m_bit = 0;
			exp_frame = 1'b0;
			exp_data = '0;
		end else begin
			exp_frame = m_take_d; // msb shows two edges after the take
			if (m_take_d) begin
				m_out = m_load;
				m_bit = 0;
				m_active = 1'b1;
			end else if (m_active) begin
				m_bit++;
			end
			for (int l = 0; l < NUM_LANES; l++) begin
				shifted = m_out[l] << m_bit;
				msbs[l] = shifted[ocyrus_pkg::BIT_DEPTH-1];
			end
			exp_data = m_active ? (msbs ^ LANE_INVERT) : '0; // pins stay low before the first word
			if (take_edge) begin
				for (int l = 0; l < NUM_LANES; l++) begin
					m_load[l] = m_full ? m_held[l] : ocyrus_pkg::IDLE_WORD;
				end
				if (m_full) begin
					sent_count++;
				end
			end
			m_take_d = take_edge;
			if (accept) begin
				m_held = in_words;
				m_full = 1'b1;
			end else if (take_edge) begin
				m_full = 1'b0;
			end
			if (m_count == ocyrus_pkg::BIT_DEPTH - 1) begin
				m_count = 0;
				m_strobes++;
				if (m_strobes == ocyrus_pkg::LOCK_STROBES) begin
					m_locked = 1'b1;
				end
			end else begin
				m_count++;
			end
		end
		exp_ready = !m_full || ((m_count == ocyrus_pkg::BIT_DEPTH - 1) && m_locked);
	end

	// pins against the model, mid cycle
	always @(negedge bit_clock) begin
		if (m_known) begin
			check_lanes("data_out", data_out, exp_data);
			check_bit("word_frame", word_frame, exp_frame);
			check_bit("locked", locked, m_locked);
			check_bit("in_ready", in_ready, exp_ready);
		end
	end

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_lanes(input string name, input logic [NUM_LANES-1:0] got,
			input logic [NUM_LANES-1:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic abort_run(input string what);
		$display("timed out waiting for %s", what);
		$display("SIMULATION FAILED");
		$finish;
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s finished with %0d errors", tests, name, errors - errors_at_start);
		errors_at_start = errors;
	endtask

	function automatic group_t random_group();
		group_t g;
		for (int l = 0; l < NUM_LANES; l++) begin
			g[l] = ocyrus_pkg::word_t'($urandom);
		end
		return g;
	endfunction

	// reset held for RESET_CYCLES edges, outputs checked after each
	task automatic apply_reset();
		reset = 1'b1;
		in_valid = 1'b0; // a pending group is dropped
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(posedge bit_clock);
			#DRIVE_DELAY;
			check_lanes("data_out", data_out, '0);
			check_bit("word_frame", word_frame, 1'b0);
			check_bit("locked", locked, 1'b0);
			check_bit("in_ready", in_ready, 1'b1);
		end
		reset = 1'b0;
	endtask

	task automatic wait_lock(output int cycles);
		logic seen;
		cycles = 0;
		seen = 1'b0;
		while (!seen) begin
			if (cycles >= LOCK_TIMEOUT) begin
				abort_run("locked to rise");
			end
			@(posedge bit_clock);
			cycles++; // rising edges since reset fell
			@(negedge bit_clock);
			seen = locked;
			check_bit("word_frame", word_frame, 1'b0); // nothing framed before lock
			check_lanes("data_out", data_out, '0);
		end
		@(posedge bit_clock);
		#DRIVE_DELAY;
	endtask

	task automatic wait_frames(input int count);
		int seen;
		int cycles;
		seen = 0;
		cycles = 0;
		while (seen < count) begin
			if (cycles >= FRAME_TIMEOUT) begin
				abort_run("word_frame");
			end
			@(negedge bit_clock);
			if (word_frame) begin
				seen++;
				cycles = 0;
			end else begin
				cycles++;
			end
			@(posedge bit_clock);
			#DRIVE_DELAY;
		end
	endtask

	// leaves in_valid high, the caller drops it or sends again
	task automatic send_group(input group_t words, output int waited);
		logic ready_seen;
		in_valid = 1'b1;
		in_words = words;
		waited = 0;
		ready_seen = 1'b0;
		while (!ready_seen) begin
			if (waited >= XFER_TIMEOUT) begin
				abort_run("in_ready to take a group");
			end
			@(negedge bit_clock);
			ready_seen = in_ready; // stable up to the next edge
			@(posedge bit_clock);
			#DRIVE_DELAY;
			waited++;
		end
		acc_count++;
	endtask

	task automatic idle_cycles(input int count);
		in_valid = 1'b0;
		for (int i = 0; i < count; i++) begin
			@(posedge bit_clock);
			#DRIVE_DELAY;
		end
	endtask

	initial begin
		int waited;
		int cycles;
		int base_acc;
		int base_sent;
		reset = 1'b1;
		in_valid = 1'b0;
		in_words = '0;
		void'($urandom(SEED));

		apply_reset();
		end_test("reset state");

		wait_lock(cycles);
		check_count("lock cycles", cycles, ocyrus_pkg::LOCK_STROBES * ocyrus_pkg::BIT_DEPTH);
		end_test("lock");

		wait_frames(4); // idle words, checked by the model
		end_test("idle words");

		base_sent = sent_count;
		for (int k = 0; k < STREAM_GROUPS; k++) begin
			idle_cycles($urandom_range(0, 12));
			send_group(random_group(), waited);
		end
		in_valid = 1'b0;
		wait_frames(3); // last group fully out
		check_count("groups sent", sent_count - base_sent, STREAM_GROUPS);
		end_test("serialization");

		base_acc = acc_count;
		base_sent = sent_count;
		for (int k = 0; k < BURST_GROUPS; k++) begin
			send_group(random_group(), waited);
			if (k >= 2) begin
				check_count("accept spacing", waited, ocyrus_pkg::BIT_DEPTH); // one per word period
			end
		end
		in_valid = 1'b0;
		wait_frames(3);
		check_count("groups sent", sent_count - base_sent, acc_count - base_acc);
		end_test("back-pressure");

		base_sent = sent_count;
		for (int k = 0; k < 3; k++) begin
			send_group(random_group(), waited);
		end
		apply_reset(); // third group still held, must vanish
		wait_lock(cycles);
		check_count("lock cycles", cycles, ocyrus_pkg::LOCK_STROBES * ocyrus_pkg::BIT_DEPTH);
		wait_frames(2);
		check_count("groups sent", sent_count - base_sent, 2);
		end_test("reset mid-stream");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
